//--- include/mdu_defs.svh
// sizing macros for the multiply/divide unit, included by the package, RTL and testbench
`ifndef MDU_DEFS_SVH
`define MDU_DEFS_SVH

// operand and result width, RV32 only
`define MDU_XLEN 32

// quotient bits retired by each divider stage
`define MDU_STAGE_BITS 4

// divider depth follows from the two above
// keep XLEN a multiple of STAGE_BITS or the quotient comes out short
`define MDU_DIV_STAGES (`MDU_XLEN / `MDU_STAGE_BITS)

// caller's tag, wide enough for the issue window of the core
`define MDU_TAG_W 6

// total latency is decode plus the divider chain, writeback is combinational
// changing STAGE_BITS trades depth against the adder chain in each stage
// 32 / 4 gives eight stages of four compare-subtract steps

`endif

//--- hw/mdu_pkg.sv
// shared types for the multiply/divide unit, imported by the RTL and the testbench
`default_nettype none

`include "mdu_defs.svh"

package mdu_pkg;

    typedef logic [`MDU_XLEN-1:0]   data_t; // operand / result word
    typedef logic [2*`MDU_XLEN-1:0] wide_t; // full product
    typedef logic [`MDU_TAG_W-1:0]  tag_t;  // opaque to the unit

    // encoding is the funct3 field of the M extension
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } mdu_op_t;

    // everything the writeback needs besides the divider state
    // rides along untouched through the divider stages
    typedef struct packed {
        mdu_op_t op;       // selects the result at the end
        tag_t    tag;      // returned with the result
        logic    dvz;      // divide by zero, division ops only
        logic    neg_q;    // quotient sign fix
        logic    neg_r;    // remainder sign fix
        data_t   dividend; // raw a, remainder value on divide by zero
        wide_t   product;  // formed at decode, travels with the op
    } mdu_side_t;

    // op[2] splits the multiply half from the divide half
    // all divide ops need b != 0 for a regular result

endpackage

`default_nettype wire

//--- hw/mdu_decode.sv
// first pipeline stage, captures an issued op, forms the product and divider magnitudes
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_decode import mdu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush_i,
    input  logic      valid_i,
    input  mdu_op_t   op_i,
    input  tag_t      tag_i,
    input  data_t     a_i,
    input  data_t     b_i,
    output logic      valid_o,
    output mdu_side_t side_o,
    output data_t     rem_o,    // partial remainder, starts at zero
    output data_t     quo_o,    // dividend magnitude, shifted out by the stages
    output data_t     dvs_o     // divisor magnitude
);

    logic                          is_div;
    logic                          sign_a;    // treat a as two's complement
    logic                          sign_b;    // treat b as two's complement
    logic                          neg_a;
    logic                          neg_b;
    logic signed [2*`MDU_XLEN+1:0] prod_full; // 33 x 33 signed, top bits unused
    data_t                         mag_a;
    data_t                         mag_b;
    mdu_side_t                     side_d;

    assign is_div = op_i inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    // MULHSU is signed a times unsigned b, the U forms are unsigned on both
    assign sign_a = op_i inside {OP_MUL, OP_MULH, OP_MULHSU, OP_DIV, OP_REM};
    assign sign_b = op_i inside {OP_MUL, OP_MULH, OP_DIV, OP_REM};

    assign neg_a = sign_a & a_i[`MDU_XLEN-1];
    assign neg_b = sign_b & b_i[`MDU_XLEN-1];

    // extend each operand by one bit so a single signed multiply covers all four
    assign prod_full = $signed({neg_a, a_i}) * $signed({neg_b, b_i});

    // magnitudes for the unsigned divider, most negative value maps to itself
    assign mag_a = neg_a ? (~a_i + 1'b1) : a_i;
    assign mag_b = neg_b ? (~b_i + 1'b1) : b_i;

    always_comb
    begin
        side_d          = '0;
        side_d.op       = op_i;
        side_d.tag      = tag_i;
        side_d.dvz      = is_div && (b_i == '0);
        side_d.neg_q    = is_div && (neg_a ^ neg_b); // signs differ
        side_d.neg_r    = is_div && neg_a;           // remainder follows dividend
        side_d.dividend = a_i;
        side_d.product  = prod_full[2*`MDU_XLEN-1:0];
    end

    // control, cleared by reset and recovery
    always_ff @(posedge clk)
    begin
        if (reset || flush_i)
        begin
            valid_o <= 1'b0;
        end
        else
        begin
            valid_o <= valid_i;
        end
    end

    // payload, only loaded on issue
    always_ff @(posedge clk)
    begin
        if (valid_i)
        begin
            side_o <= side_d;
            rem_o  <= '0;
            quo_o  <= mag_a;
            dvs_o  <= mag_b;
        end
    end

endmodule

`default_nettype wire

//--- hw/div_stage.sv
// one registered stage of the restoring divider, chained by the top level
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module div_stage import mdu_pkg::*; #(
    parameter type side_t = logic  // sideband, passed through untouched
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  flush_i,
    input  logic  valid_i,
    input  side_t side_i,
    input  data_t rem_i,
    input  data_t quo_i,
    input  data_t dvs_i,
    output logic  valid_o,
    output side_t side_o,
    output data_t rem_o,
    output data_t quo_o,
    output data_t dvs_o
);

    data_t rem_nxt;
    data_t quo_nxt; // dividend bits on top, quotient bits filling in below

    // MDU_STAGE_BITS compare-subtract steps in one cycle
    always_comb
    begin
        logic [`MDU_XLEN:0] trial; // shifted remainder needs one extra bit
        rem_nxt = rem_i;
        quo_nxt = quo_i;
        for (int i = 0; i < `MDU_STAGE_BITS; i++)
        begin
            trial   = {rem_nxt, quo_nxt[`MDU_XLEN-1]}; // bring down next dividend bit
            quo_nxt = {quo_nxt[`MDU_XLEN-2:0], 1'b0};
            if (trial >= {1'b0, dvs_i})
            begin
                trial      = trial - {1'b0, dvs_i}; // restore not needed
                quo_nxt[0] = 1'b1;
            end
            rem_nxt = trial[`MDU_XLEN-1:0]; // always below divisor here
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush_i)
        begin
            valid_o <= 1'b0;
        end
        else
        begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (valid_i)
        begin
            side_o <= side_i;
            rem_o  <= rem_nxt;
            quo_o  <= quo_nxt;
            dvs_o  <= dvs_i;   // divisor carried for the next stage
        end
    end

endmodule

`default_nettype wire

//--- hw/mdu_writeback.sv
// last pipeline step, fixes signs and picks the result, purely combinational
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_writeback import mdu_pkg::*; (
    input  logic      valid_i,
    input  mdu_side_t side_i,
    input  data_t     rem_i,        // unsigned remainder from the last stage
    input  data_t     quo_i,        // unsigned quotient from the last stage
    output logic      valid_o,
    output tag_t      tag_o,
    output data_t     result_o,
    output logic      exception_o
);

    data_t quo_fix;
    data_t rem_fix;

    // sign correction, then the architectural divide-by-zero values on top
    always_comb
    begin
        quo_fix = side_i.neg_q ? (~quo_i + 1'b1) : quo_i;
        rem_fix = side_i.neg_r ? (~rem_i + 1'b1) : rem_i;
        if (side_i.dvz)
        begin
            quo_fix = '1;              // all ones for both signed and unsigned
            rem_fix = side_i.dividend; // dividend unchanged
        end
    end

    assign valid_o = valid_i;

    always_comb
    begin
        result_o    = '0;
        tag_o       = '0;
        exception_o = 1'b0;
        if (valid_i)
        begin
            tag_o       = side_i.tag;
            exception_o = side_i.dvz; // only set for division ops
            case (side_i.op)
                OP_MUL:
                begin
                    result_o = side_i.product[`MDU_XLEN-1:0];
                end
                OP_MULH, OP_MULHSU, OP_MULHU:
                begin
                    result_o = side_i.product[2*`MDU_XLEN-1:`MDU_XLEN]; // upper half
                end
                OP_DIV, OP_DIVU:
                begin
                    result_o = quo_fix;
                end
                default:
                begin
                    result_o = rem_fix; // REM, REMU
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/mdu_top.sv
// top level of the multiply/divide unit, decode then divider stages then writeback
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_top import mdu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    valid_i,    // one op per cycle, never stalls
    input  logic    flush_i,    // drops everything in flight
    input  mdu_op_t op_i,
    input  tag_t    tag_i,
    input  data_t   a_i,
    input  data_t   b_i,
    output logic    valid_o,
    output tag_t    tag_o,
    output data_t   result_o,
    output logic    exception_o
);

    localparam int STAGES = `MDU_DIV_STAGES;

    // index 0 is the decode output, index STAGES the last divider stage
    logic      valid_w [0:STAGES];
    mdu_side_t side_w  [0:STAGES];
    data_t     rem_w   [0:STAGES];
    data_t     quo_w   [0:STAGES];
    data_t     dvs_w   [0:STAGES];

    mdu_decode decode_i (
        .clk     (clk),
        .reset   (reset),
        .flush_i (flush_i),
        .valid_i (valid_i),
        .op_i    (op_i),
        .tag_i   (tag_i),
        .a_i     (a_i),
        .b_i     (b_i),
        .valid_o (valid_w[0]),
        .side_o  (side_w[0]),
        .rem_o   (rem_w[0]),
        .quo_o   (quo_w[0]),
        .dvs_o   (dvs_w[0])
    );

    // multiplies ride the same chain so results stay in issue order
    for (genvar s = 0; s < STAGES; s++)
    begin : g_stage
        div_stage #(
            .side_t (mdu_side_t)
        ) div_stage_i (
            .clk     (clk),
            .reset   (reset),
            .flush_i (flush_i),
            .valid_i (valid_w[s]),
            .side_i  (side_w[s]),
            .rem_i   (rem_w[s]),
            .quo_i   (quo_w[s]),
            .dvs_i   (dvs_w[s]),
            .valid_o (valid_w[s+1]),
            .side_o  (side_w[s+1]),
            .rem_o   (rem_w[s+1]),
            .quo_o   (quo_w[s+1]),
            .dvs_o   (dvs_w[s+1])
        );
    end

    // no register here, latency is decode plus the stage count
    mdu_writeback writeback_i (
        .valid_i     (valid_w[STAGES]),
        .side_i      (side_w[STAGES]),
        .rem_i       (rem_w[STAGES]),
        .quo_i       (quo_w[STAGES]),
        .valid_o     (valid_o),
        .tag_o       (tag_o),
        .result_o    (result_o),
        .exception_o (exception_o)
    );

endmodule

`default_nettype wire

//--- bench/clk_gen.sv
// testbench clock and reset source, instanced once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic reset_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // synchronous reset, released just after the last reset edge
    initial
    begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 reset_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/mdu_tb.sv
// testbench top, drives random and directed ops into the unit and checks each result in order
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_tb import mdu_pkg::*; ();

    localparam int    LATENCY   = 9;  // issue edge to the edge that takes the result
    localparam time   DRIVE_DLY = 2;  // inputs move this long after the rising edge
    localparam data_t MIN_V     = {1'b1, {(`MDU_XLEN-1){1'b0}}}; // most negative

    typedef struct packed {
        data_t res;
        logic  exc;
    } ref_t;

    logic    clk;
    logic    reset;
    logic    valid_i;
    logic    flush_i;
    mdu_op_t op_i;
    tag_t    tag_i;
    data_t   a_i;
    data_t   b_i;
    logic    valid_o;
    tag_t    tag_o;
    data_t   result_o;
    logic    exception_o;

    logic [15:0] lfsr_state = 16'd26655;
    int          cyc = 0;     // rising edges seen so far
    tag_t        next_tag = '0;

    // expected results, oldest first
    data_t exp_res_q [$];
    tag_t  exp_tag_q [$];
    logic  exp_exc_q [$];
    int    exp_cyc_q [$]; // issue edge

    clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) clk_gen_i (.clk_o(clk), .reset_o(reset));

    mdu_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .valid_i     (valid_i),
        .flush_i     (flush_i),
        .op_i        (op_i),
        .tag_i       (tag_i),
        .a_i         (a_i),
        .b_i         (b_i),
        .valid_o     (valid_o),
        .tag_o       (tag_o),
        .result_o    (result_o),
        .exception_o (exception_o)
    );

    always @(posedge clk) cyc <= cyc + 1;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic data_t rand_bits(input int n);
        data_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
            v = {v[`MDU_XLEN-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // corners turn up often, zero included so divides hit b == 0
    function automatic data_t rand_operand();
        case (rand_bits(3))
            0:       return '0;
            1:       return '1;
            2:       return MIN_V;
            3:       return data_t'(1);
            default: return rand_bits(`MDU_XLEN);
        endcase
    endfunction

    function automatic mdu_op_t rand_op(input logic div_half);
        data_t v;
        v = rand_bits(2);
        return mdu_op_t'({div_half, v[1:0]}); // funct3 bit 2 picks divide
    endfunction

    // expected result straight from the M extension rules
    function automatic ref_t ref_model(input mdu_op_t op, input data_t a, input data_t b);
        ref_t  r;
        wide_t xa;
        wide_t xb;
        wide_t p;
        logic  ovf;
        r   = '0;
        ovf = (a == MIN_V) && (b == '1); // signed overflow case
        xa  = (op == OP_MULHU) ? {{`MDU_XLEN{1'b0}}, a} : {{`MDU_XLEN{a[`MDU_XLEN-1]}}, a};
        xb  = (op == OP_MUL || op == OP_MULH) ? {{`MDU_XLEN{b[`MDU_XLEN-1]}}, b}
                                              : {{`MDU_XLEN{1'b0}}, b};
        p   = xa * xb; // low 64 bits exact for any sign mix
        case (op)
            OP_MUL:                      r.res = p[`MDU_XLEN-1:0];
            OP_MULH, OP_MULHSU, OP_MULHU: r.res = p[2*`MDU_XLEN-1:`MDU_XLEN];
            OP_DIV:  r.res = (b == '0) ? '1 : ovf ? a : data_t'($signed(a) / $signed(b));
            OP_DIVU: r.res = (b == '0) ? '1 : a / b;
            OP_REM:  r.res = (b == '0) ? a : ovf ? '0 : data_t'($signed(a) % $signed(b));
            default: r.res = (b == '0) ? a : a % b;
        endcase
        r.exc = op[2] && (b == '0); // divides only
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_data(input string name, input data_t exp_v, input data_t act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("ERR t=%0t %s expected %h got %h", $time, name, exp_v, act_v));
    endtask

    task automatic check_tag(input string name, input tag_t exp_v, input tag_t act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("ERR t=%0t %s expected %h got %h", $time, name, exp_v, act_v));
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("ERR t=%0t %s expected %b got %b", $time, name, exp_v, act_v));
    endtask

    // compare side, outputs are settled by the falling edge
    always @(negedge clk)
    begin
        int lat;
        if (!reset && valid_o)
        begin
            if (exp_res_q.size() == 0)
                abort_run("valid_o went high with no operation outstanding");
            else
            begin
                lat = cyc + 1 - exp_cyc_q.pop_front(); // taken at the next edge
                check_tag("tag_o", exp_tag_q.pop_front(), tag_o);
                check_data("result_o", exp_res_q.pop_front(), result_o);
                check_flag("exception_o", exp_exc_q.pop_front(), exception_o);
                if (lat != LATENCY)
                    abort_run($sformatf("result for tag %0d came %0d cycles after issue",
                                        tag_o, lat));
            end
        end
    end

    task automatic issue(input mdu_op_t op, input data_t a, input data_t b);
        ref_t r;
        r       = ref_model(op, a, b);
        valid_i = 1'b1;
        op_i    = op;
        tag_i   = next_tag;
        a_i     = a;
        b_i     = b;
        exp_res_q.push_back(r.res);
        exp_tag_q.push_back(next_tag);
        exp_exc_q.push_back(r.exc);
        exp_cyc_q.push_back(cyc + 1); // sampled at the coming edge
        next_tag = next_tag + 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic idle(input int n);
        valid_i = 1'b0;
        repeat (n)
        begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (reset !== 1'b0) // still unknown at time zero
        begin
            @(posedge clk);
            n++;
            if (n > 10)
                abort_run("reset never released");
        end
        #DRIVE_DLY;
    endtask

    task automatic drain();
        int n;
        n = 0;
        valid_i = 1'b0;
        while (exp_res_q.size() != 0)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
            if (n > 3 * LATENCY)
                abort_run("timed out waiting for outstanding results");
        end
    endtask

    // ops in flight plus one issued with the flush, none may come out
    task automatic flush_test();
        for (int k = 0; k < LATENCY - 1; k++) // decode and every stage hold an op
            issue(rand_op(rand_bits(1) != 0), rand_operand(), rand_operand());
        valid_i = 1'b1;
        flush_i = 1'b1;
        op_i    = OP_DIV;
        tag_i   = next_tag;
        a_i     = rand_operand();
        b_i     = rand_operand();
        exp_res_q.delete();
        exp_tag_q.delete();
        exp_exc_q.delete();
        exp_cyc_q.delete();
        @(posedge clk);
        #DRIVE_DLY;
        flush_i = 1'b0;
        idle(LATENCY + 6); // compare process trips on any stray valid_o
        for (int k = 0; k < 40; k++)
            issue(rand_op(rand_bits(1) != 0), rand_operand(), rand_operand());
        drain();
    endtask

    initial
    begin
        valid_i = 1'b0;
        flush_i = 1'b0;
        op_i    = OP_MUL;
        tag_i   = '0;
        a_i     = '0;
        b_i     = '0;
        wait_reset();
        idle(20); // quiet after reset
        for (int k = 0; k < 200; k++)
            issue(rand_op(1'b0), rand_operand(), rand_operand());
        issue(OP_MULH, MIN_V, MIN_V);
        issue(OP_MULHSU, '1, '1);
        issue(OP_MULHU, '1, '1);
        drain();
        for (int k = 0; k < 200; k++)
            issue(rand_op(1'b1), rand_operand(), rand_operand());
        issue(OP_DIV, MIN_V, '1);
        issue(OP_REM, MIN_V, '1);
        issue(OP_DIV, rand_bits(`MDU_XLEN), '0);
        issue(OP_DIVU, rand_bits(`MDU_XLEN), '0);
        issue(OP_REM, rand_bits(`MDU_XLEN), '0);
        issue(OP_REMU, rand_bits(`MDU_XLEN), '0);
        drain();
        for (int k = 0; k < 300; k++)
        begin
            if (rand_bits(2) == 0)
                idle(1); // bubble about one cycle in four
            else
                issue(rand_op(rand_bits(1) != 0), rand_operand(), rand_operand());
        end
        drain();
        flush_test();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
hw/mdu_pkg.sv
hw/mdu_decode.sv
hw/div_stage.sv
hw/mdu_writeback.sv
hw/mdu_top.sv
bench/clk_gen.sv
bench/mdu_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and judge the run from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f compile.f --top-module mdu_tb -o mdu_sim

# $fatal exits non-zero, so the log decides the verdict
./obj_dir/mdu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run_sim: FAIL"
    exit 1
fi
echo "run_sim: PASS"
exit 0
